// File: design/tx_pipeline_pkg.sv
package tx_pipeline_pkg;

  // Datapath is fixed at 64 bits on both ports
  localparam int data_width = 64;

  // One strobe bit per byte
  localparam int strb_width = data_width / 8;

  // User sideband carried with each AXI-Stream beat
  localparam int user_width = 4;

  // User bit positions and their TRN sideband meaning
  localparam int user_ecrc_bit   = 0;
  localparam int user_errfwd_bit = 1;
  localparam int user_str_bit    = 2;
  localparam int user_dsc_bit    = 3;

  // Strobe of the top byte in the upper dword
  // Set means both dwords of the final beat carry data
  localparam int strb_upper_dw_bit = 7;

  // Skid buffer selection for the output register
  typedef enum logic [1:0] {
    HOLD,
    PREVIOUS,
    CURRENT
  } buf_state_e;

  // Link controller state
  typedef enum logic [1:0] {
    LINK_DOWN,
    FLUSHING,
    RUNNING
  } link_state_e;

endpackage

// File: design/tx_skid_buffer.sv
`timescale 1ns/1ns

module tx_skid_buffer
  import tx_pipeline_pkg::*;
(
  input  logic                  com_iclk,
  input  logic                  com_sysrst,
  // User beat
  input  logic [data_width-1:0] s_axis_tx_tdata,
  input  logic                  s_axis_tx_tvalid,
  input  logic [strb_width-1:0] s_axis_tx_tstrb,
  input  logic                  s_axis_tx_tlast,
  input  logic [user_width-1:0] s_axis_tx_tuser,
  input  logic                  s_axis_tx_tready,
  // TRN handshake
  input  logic                  trn_tsrc_rdy,
  input  logic                  trn_tdst_rdy,
  // Registered beat towards the formatter
  output logic [data_width-1:0] reg_tdata,
  output logic                  reg_tvalid,
  output logic [strb_width-1:0] reg_tstrb,
  output logic                  reg_tlast,
  output logic [user_width-1:0] reg_tuser
);

  logic [data_width-1:0] tdata_prev;
  logic                  tvalid_prev;
  logic [strb_width-1:0] tstrb_prev;
  logic                  tlast_prev;
  logic [user_width-1:0] tuser_prev;
  logic                  data_hold;
  logic                  hold_q;
  buf_state_e            buf_sel;

  // ---------------------------------------------------------------------------
  // Previous-value copy
  // ---------------------------------------------------------------------------

  // tready reaches the user a cycle late, so the beat shown while the
  // TRN side stalls still has to be caught somewhere
  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      tvalid_prev <= 1'b0;
    end else if (s_axis_tx_tready) begin
      tvalid_prev <= s_axis_tx_tvalid;
    end
  end

  always_ff @(posedge com_iclk) begin
    if (s_axis_tx_tready) begin
      tdata_prev <= s_axis_tx_tdata;
      tstrb_prev <= s_axis_tx_tstrb;
      tlast_prev <= s_axis_tx_tlast;
      tuser_prev <= s_axis_tx_tuser;
    end
  end

  // ---------------------------------------------------------------------------
  // Output register selection
  // ---------------------------------------------------------------------------

  // Offered beat not taken by the core
  assign data_hold = trn_tsrc_rdy && !trn_tdst_rdy;

  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      hold_q <= 1'b0;
    end else begin
      hold_q <= data_hold;
    end
  end

  // Right after a stall the live input is one beat ahead
  always_comb begin
    if (data_hold) begin
      buf_sel = HOLD;
    end else if (hold_q) begin
      buf_sel = PREVIOUS;
    end else begin
      buf_sel = CURRENT;
    end
  end

  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      reg_tvalid <= 1'b0;
    end else begin
      case (buf_sel)
        PREVIOUS: reg_tvalid <= tvalid_prev;
        CURRENT:  reg_tvalid <= s_axis_tx_tvalid;
        default:  reg_tvalid <= reg_tvalid;
      endcase
    end
  end

  // Payload follows the same selection
  always_ff @(posedge com_iclk) begin
    case (buf_sel)
      PREVIOUS: begin
        reg_tdata <= tdata_prev;
        reg_tstrb <= tstrb_prev;
        reg_tlast <= tlast_prev;
        reg_tuser <= tuser_prev;
      end
      CURRENT: begin
        reg_tdata <= s_axis_tx_tdata;
        reg_tstrb <= s_axis_tx_tstrb;
        reg_tlast <= s_axis_tx_tlast;
        reg_tuser <= s_axis_tx_tuser;
      end
      default: begin
        reg_tdata <= reg_tdata;
        reg_tstrb <= reg_tstrb;
        reg_tlast <= reg_tlast;
        reg_tuser <= reg_tuser;
      end
    endcase
  end

endmodule

// File: design/tx_link_ctrl.sv
`timescale 1ns/1ns

module tx_link_ctrl
  import tx_pipeline_pkg::*;
(
  input  logic com_iclk,
  input  logic com_sysrst,
  // User side
  input  logic s_axis_tx_tvalid,
  input  logic s_axis_tx_tlast,
  output logic s_axis_tx_tready,
  // TRN side
  input  logic trn_lnk_up,
  input  logic trn_tsrc_rdy,
  input  logic trn_tdst_rdy,
  output logic disable_trn
);

  link_state_e state_q;
  link_state_e state_d;
  logic        axi_beat_live;
  logic        axi_end_packet;
  logic        axi_in_packet;
  logic        pkt_open;

  assign axi_beat_live  = s_axis_tx_tvalid && s_axis_tx_tready;
  assign axi_end_packet = axi_beat_live && s_axis_tx_tlast;

  // User side packet tracking
  // pkt_open is the in-packet flag as it will be after this edge
  assign pkt_open = axi_beat_live ? !s_axis_tx_tlast : axi_in_packet;

  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      axi_in_packet <= 1'b0;
    end else begin
      axi_in_packet <= pkt_open;
    end
  end

  // ---------------------------------------------------------------------------
  // Link state
  // ---------------------------------------------------------------------------

  always_comb begin
    if (state_q == FLUSHING && !axi_end_packet) begin
      // Keep draining until tlast goes by
      state_d = FLUSHING;
    end else if (!trn_lnk_up) begin
      // Drop in the middle of a user packet starts a flush
      state_d = pkt_open ? FLUSHING : LINK_DOWN;
    end else begin
      state_d = RUNNING;
    end
  end

  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      state_q <= LINK_DOWN;
    end else begin
      state_q <= state_d;
    end
  end

  // ---------------------------------------------------------------------------
  // User ready
  // ---------------------------------------------------------------------------

  // Flushing swallows the rest of the packet
  // With the link up ready follows the core taking data or an empty stage
  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      s_axis_tx_tready <= 1'b0;
    end else if (state_d == FLUSHING) begin
      s_axis_tx_tready <= 1'b1;
    end else if (trn_lnk_up) begin
      s_axis_tx_tready <= trn_tdst_rdy || !trn_tsrc_rdy;
    end else begin
      s_axis_tx_tready <= 1'b0;
    end
  end

  // TRN side stays off from link-down until the user side is taking beats
  // again, which lets the skid buffer refill with a clean beat first
  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      disable_trn <= 1'b1;
    end else if (!trn_lnk_up) begin
      disable_trn <= 1'b1;
    end else if (state_q != FLUSHING && s_axis_tx_tready) begin
      disable_trn <= 1'b0;
    end
  end

endmodule

// File: design/tx_trn_format.sv
`timescale 1ns/1ns

module tx_trn_format
  import tx_pipeline_pkg::*;
(
  input  logic                  com_iclk,
  input  logic                  com_sysrst,
  // Registered beat from the skid buffer
  input  logic [data_width-1:0] reg_tdata,
  input  logic                  reg_tvalid,
  input  logic [strb_width-1:0] reg_tstrb,
  input  logic                  reg_tlast,
  input  logic [user_width-1:0] reg_tuser,
  input  logic                  disable_trn,
  // TRN port
  input  logic                  trn_tdst_rdy,
  input  logic                  trn_lnk_up,
  output logic [data_width-1:0] trn_td,
  output logic                  trn_tsof,
  output logic                  trn_teof,
  output logic                  trn_tsrc_rdy,
  output logic                  trn_trem,
  output logic                  trn_terrfwd,
  output logic                  trn_tstr,
  output logic                  trn_tecrc_gen,
  output logic                  trn_tsrc_dsc
);

  logic trn_in_packet;
  logic trn_xfer;

  // ---------------------------------------------------------------------------
  // Data and sideband mapping
  // ---------------------------------------------------------------------------

  // TRN puts the first dword in the upper half, AXI in the lower half
  assign trn_td = {reg_tdata[data_width/2-1:0], reg_tdata[data_width-1:data_width/2]};

  // Remainder set when the upper dword of the last beat is valid
  assign trn_trem = reg_tstrb[strb_upper_dw_bit];

  assign trn_teof      = reg_tlast;
  assign trn_tecrc_gen = reg_tuser[user_ecrc_bit];
  assign trn_terrfwd   = reg_tuser[user_errfwd_bit];
  assign trn_tstr      = reg_tuser[user_str_bit];
  assign trn_tsrc_dsc  = reg_tuser[user_dsc_bit];

  // Nothing goes out while the link controller holds the port off
  assign trn_tsrc_rdy = reg_tvalid && !disable_trn;

  assign trn_xfer = trn_tsrc_rdy && trn_tdst_rdy;

  // ---------------------------------------------------------------------------
  // Start of packet
  // ---------------------------------------------------------------------------

  // First valid beat outside a packet
  assign trn_tsof = reg_tvalid && !trn_in_packet;

  // Single-beat packets never enter the in-packet state
  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      trn_in_packet <= 1'b0;
    end else if (!trn_lnk_up) begin
      trn_in_packet <= 1'b0;
    end else if (trn_xfer && trn_tsof && !trn_teof) begin
      trn_in_packet <= 1'b1;
    end else if (trn_xfer && trn_teof) begin
      trn_in_packet <= 1'b0;
    end
  end

endmodule

// File: design/tx_pipeline_top.sv
`timescale 1ns/1ns

module tx_pipeline_top
  import tx_pipeline_pkg::*;
(
  input  logic                  com_iclk,
  input  logic                  com_sysrst,
  // AXI-Stream user port
  input  logic [data_width-1:0] s_axis_tx_tdata,
  input  logic                  s_axis_tx_tvalid,
  output logic                  s_axis_tx_tready,
  input  logic [strb_width-1:0] s_axis_tx_tstrb,
  input  logic                  s_axis_tx_tlast,
  input  logic [user_width-1:0] s_axis_tx_tuser,
  // TRN port
  output logic [data_width-1:0] trn_td,
  output logic                  trn_tsof,
  output logic                  trn_teof,
  output logic                  trn_tsrc_rdy,
  input  logic                  trn_tdst_rdy,
  output logic                  trn_tsrc_dsc,
  output logic                  trn_trem,
  output logic                  trn_terrfwd,
  output logic                  trn_tstr,
  output logic                  trn_tecrc_gen,
  input  logic                  trn_lnk_up
);

  // Register stage between the two ports
  logic [data_width-1:0] reg_tdata;
  logic                  reg_tvalid;
  logic [strb_width-1:0] reg_tstrb;
  logic                  reg_tlast;
  logic [user_width-1:0] reg_tuser;
  logic                  disable_trn;

  tx_skid_buffer i_tx_skid_buffer (
    .com_iclk         (com_iclk),
    .com_sysrst       (com_sysrst),
    .s_axis_tx_tdata  (s_axis_tx_tdata),
    .s_axis_tx_tvalid (s_axis_tx_tvalid),
    .s_axis_tx_tstrb  (s_axis_tx_tstrb),
    .s_axis_tx_tlast  (s_axis_tx_tlast),
    .s_axis_tx_tuser  (s_axis_tx_tuser),
    .s_axis_tx_tready (s_axis_tx_tready),
    .trn_tsrc_rdy     (trn_tsrc_rdy),
    .trn_tdst_rdy     (trn_tdst_rdy),
    .reg_tdata        (reg_tdata),
    .reg_tvalid       (reg_tvalid),
    .reg_tstrb        (reg_tstrb),
    .reg_tlast        (reg_tlast),
    .reg_tuser        (reg_tuser)
  );

  // Ready generation and link-down flush
  tx_link_ctrl i_tx_link_ctrl (
    .com_iclk         (com_iclk),
    .com_sysrst       (com_sysrst),
    .s_axis_tx_tvalid (s_axis_tx_tvalid),
    .s_axis_tx_tlast  (s_axis_tx_tlast),
    .s_axis_tx_tready (s_axis_tx_tready),
    .trn_lnk_up       (trn_lnk_up),
    .trn_tsrc_rdy     (trn_tsrc_rdy),
    .trn_tdst_rdy     (trn_tdst_rdy),
    .disable_trn      (disable_trn)
  );

  tx_trn_format i_tx_trn_format (
    .com_iclk      (com_iclk),
    .com_sysrst    (com_sysrst),
    .reg_tdata     (reg_tdata),
    .reg_tvalid    (reg_tvalid),
    .reg_tstrb     (reg_tstrb),
    .reg_tlast     (reg_tlast),
    .reg_tuser     (reg_tuser),
    .disable_trn   (disable_trn),
    .trn_tdst_rdy  (trn_tdst_rdy),
    .trn_lnk_up    (trn_lnk_up),
    .trn_td        (trn_td),
    .trn_tsof      (trn_tsof),
    .trn_teof      (trn_teof),
    .trn_tsrc_rdy  (trn_tsrc_rdy),
    .trn_trem      (trn_trem),
    .trn_terrfwd   (trn_terrfwd),
    .trn_tstr      (trn_tstr),
    .trn_tecrc_gen (trn_tecrc_gen),
    .trn_tsrc_dsc  (trn_tsrc_dsc)
  );

endmodule

// File: include/tx_vectors.svh
`ifndef TX_VECTORS_SVH
`define TX_VECTORS_SVH

// Packet table for the TX converter testbench
// Name is an ASCII string packed into 16 bytes
typedef struct packed {
  logic [127:0]                              name;
  logic [15:0]                               num_beats;
  logic [31:0]                               data_seed;
  logic [tx_pipeline_pkg::strb_width-1:0]    last_strb;
  logic [tx_pipeline_pkg::user_width-1:0]    user_bits;
  logic [7:0]                                throttle_pct;
  logic                                      link_drop;
} tx_vector_t;

localparam int num_vectors = 7;

// Sum of num_beats over all rows
localparam int total_beats = 45;

// Name, beats, seed, final strobe, user bits, tdst_rdy low percent, link drop
localparam tx_vector_t tx_vectors [num_vectors] = '{
  '{"single_beat",    16'd1,  32'h0000_1000, 8'h0f, 4'h0, 8'd0,  1'b0},
  '{"short_pkt",      16'd3,  32'h0000_2000, 8'hff, 4'h1, 8'd0,  1'b0},
  '{"long_pkt",       16'd8,  32'h0000_3000, 8'h0f, 4'h2, 8'd0,  1'b0},
  '{"throttle_light", 16'd6,  32'h0000_4000, 8'hff, 4'h4, 8'd25, 1'b0},
  '{"throttle_heavy", 16'd10, 32'h0000_5000, 8'h0f, 4'h8, 8'd60, 1'b0},
  '{"link_drop",      16'd12, 32'h0000_6000, 8'hff, 4'h3, 8'd0,  1'b1},
  '{"after_drop",     16'd5,  32'h0000_7000, 8'h0f, 4'h5, 8'd30, 1'b0}
};

`endif

// File: test/tb_tx_pipeline.sv
`timescale 1ns/1ns

module tb_tx_pipeline
  import tx_pipeline_pkg::*;
;

  `include "tx_vectors.svh"

  // Run limit in clock cycles
  localparam int cycle_limit = total_beats * 8 + 200;

  typedef struct packed {
    logic [data_width-1:0] data;
    logic [strb_width-1:0] strb;
    logic                  last;
    logic [user_width-1:0] user;
    logic                  sof;
  } beat_t;

  logic                  com_iclk;
  logic                  com_sysrst;
  logic [data_width-1:0] s_axis_tx_tdata;
  logic                  s_axis_tx_tvalid;
  logic                  s_axis_tx_tready;
  logic [strb_width-1:0] s_axis_tx_tstrb;
  logic                  s_axis_tx_tlast;
  logic [user_width-1:0] s_axis_tx_tuser;
  logic [data_width-1:0] trn_td;
  logic                  trn_tsof;
  logic                  trn_teof;
  logic                  trn_tsrc_rdy;
  logic                  trn_tdst_rdy;
  logic                  trn_tsrc_dsc;
  logic                  trn_trem;
  logic                  trn_terrfwd;
  logic                  trn_tstr;
  logic                  trn_tecrc_gen;
  logic                  trn_lnk_up;

  integer       seed = 32'hd782;
  int           error_count = 0;
  int           check_count = 0;
  int           cycle_count = 0;
  int           link_low_cycles = 0;
  int           pct_cur = 0;
  logic         link_next = 1'b1;
  logic         drop_pkt = 1'b0;
  logic         sof_next = 1'b1;
  logic [127:0] cur_name = "reset";
  beat_t        scoreboard [$];

  tx_pipeline_top i_tx_pipeline_top (
    .com_iclk         (com_iclk),
    .com_sysrst       (com_sysrst),
    .s_axis_tx_tdata  (s_axis_tx_tdata),
    .s_axis_tx_tvalid (s_axis_tx_tvalid),
    .s_axis_tx_tready (s_axis_tx_tready),
    .s_axis_tx_tstrb  (s_axis_tx_tstrb),
    .s_axis_tx_tlast  (s_axis_tx_tlast),
    .s_axis_tx_tuser  (s_axis_tx_tuser),
    .trn_td           (trn_td),
    .trn_tsof         (trn_tsof),
    .trn_teof         (trn_teof),
    .trn_tsrc_rdy     (trn_tsrc_rdy),
    .trn_tdst_rdy     (trn_tdst_rdy),
    .trn_tsrc_dsc     (trn_tsrc_dsc),
    .trn_trem         (trn_trem),
    .trn_terrfwd      (trn_terrfwd),
    .trn_tstr         (trn_tstr),
    .trn_tecrc_gen    (trn_tecrc_gen),
    .trn_lnk_up       (trn_lnk_up)
  );

  // 4 ns clock
  initial com_iclk = 1'b0;
  always #2 com_iclk = ~com_iclk;

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  task automatic check_value(input string field, input logic [63:0] exp_val,
                             input logic [63:0] act_val);
    check_count++;
    assert (exp_val === act_val) else begin
      error_count++;
      $display("MISMATCH %0s %0s: expected %h actual %h", cur_name, field, exp_val, act_val);
    end
  endtask

  // One clock edge with link and random core throttle driven on it
  task automatic step_cycle();
    int rnd;
    @(posedge com_iclk);
    rnd = $random(seed) & 32'h7fff_ffff;
    trn_lnk_up   <= link_next;
    trn_tdst_rdy <= link_next && ((rnd % 100) >= pct_cur);
  endtask

  task automatic send_packet(input int v);
    int   n_beats;
    logic accepted;
    n_beats  = int'(tx_vectors[v].num_beats);
    cur_name = tx_vectors[v].name;
    pct_cur  = int'(tx_vectors[v].throttle_pct);
    for (int i = 0; i < n_beats; i++) begin
      s_axis_tx_tvalid <= 1'b1;
      s_axis_tx_tdata  <= {tx_vectors[v].data_seed + 32'(i), 32'($random(seed))};
      s_axis_tx_tstrb  <= (i == n_beats - 1) ? tx_vectors[v].last_strb : 8'hff;
      s_axis_tx_tlast  <= (i == n_beats - 1);
      s_axis_tx_tuser  <= tx_vectors[v].user_bits;
      // Link goes down in the middle of the packet
      if (tx_vectors[v].link_drop && i == n_beats / 2) begin
        link_next = 1'b0;
        drop_pkt  = 1'b1;
      end
      accepted = 1'b0;
      while (!accepted) begin
        @(negedge com_iclk);
        accepted = s_axis_tx_tready;
        step_cycle();
      end
    end
    s_axis_tx_tvalid <= 1'b0;
    s_axis_tx_tlast  <= 1'b0;
    if (tx_vectors[v].link_drop) begin
      repeat (3) step_cycle();
      link_next = 1'b1;
      repeat (6) step_cycle();
    end
    // Drain the pipe before the next row
    while (scoreboard.size() != 0) begin
      step_cycle();
    end
    repeat (2) step_cycle();
  endtask

  // --------------------------------------------------------------------------
  // Scoreboard sampled mid-cycle
  // --------------------------------------------------------------------------

  always @(negedge com_iclk) begin
    beat_t exp_beat;
    beat_t new_beat;
    if (!com_sysrst) begin
      // Beats still in the pipe are lost on link-down
      if (!trn_lnk_up) begin
        if (link_low_cycles == 0) begin
          scoreboard.delete();
          sof_next = 1'b1;
        end
        link_low_cycles++;
      end else begin
        link_low_cycles = 0;
      end
      if (drop_pkt && link_low_cycles >= 2) begin
        check_count++;
        assert (s_axis_tx_tready) else begin
          error_count++;
          $display("%0s: user ready dropped while flushing a packet", cur_name);
        end
      end
      // Once an edge has seen the link down the TRN side offers nothing
      if (link_low_cycles >= 2) begin
        check_count++;
        assert (!trn_tsrc_rdy) else begin
          error_count++;
          $display("%0s: TRN source ready while the link is down", cur_name);
        end
      end
      if (trn_tsrc_rdy && trn_tdst_rdy) begin
        check_count++;
        assert (scoreboard.size() != 0) else begin
          error_count++;
          $display("%0s: TRN transfer with no accepted beat pending", cur_name);
        end
        if (scoreboard.size() != 0) begin
          exp_beat = scoreboard.pop_front();
          // TRN carries the dwords in swapped order
          check_value("td", {exp_beat.data[31:0], exp_beat.data[63:32]}, trn_td);
          check_value("tsof", 64'(exp_beat.sof), 64'(trn_tsof));
          check_value("teof", 64'(exp_beat.last), 64'(trn_teof));
          if (exp_beat.last) begin
            check_value("trem", 64'(exp_beat.strb[7]), 64'(trn_trem));
          end
          check_value("tecrc_gen", 64'(exp_beat.user[0]), 64'(trn_tecrc_gen));
          check_value("terrfwd", 64'(exp_beat.user[1]), 64'(trn_terrfwd));
          check_value("tstr", 64'(exp_beat.user[2]), 64'(trn_tstr));
          check_value("tsrc_dsc", 64'(exp_beat.user[3]), 64'(trn_tsrc_dsc));
        end
      end
      if (s_axis_tx_tvalid && s_axis_tx_tready) begin
        if (trn_lnk_up) begin
          new_beat.data = s_axis_tx_tdata;
          new_beat.strb = s_axis_tx_tstrb;
          new_beat.last = s_axis_tx_tlast;
          new_beat.user = s_axis_tx_tuser;
          new_beat.sof  = sof_next;
          scoreboard.push_back(new_beat);
          sof_next = s_axis_tx_tlast;
        end
        if (s_axis_tx_tlast) begin
          drop_pkt = 1'b0;
        end
      end
    end
  end

  // Timeout guard
  always @(posedge com_iclk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Regression failed");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------

  initial begin
    com_sysrst       = 1'b1;
    s_axis_tx_tdata  = '0;
    s_axis_tx_tvalid = 1'b0;
    s_axis_tx_tstrb  = '0;
    s_axis_tx_tlast  = 1'b0;
    s_axis_tx_tuser  = '0;
    trn_tdst_rdy     = 1'b0;
    trn_lnk_up       = 1'b1;
    repeat (5) @(posedge com_iclk);
    com_sysrst <= 1'b0;
    // Nothing offered yet, both sides still closed
    @(negedge com_iclk);
    check_value("reset tready", 64'(1'b0), 64'(s_axis_tx_tready));
    check_value("reset tsrc_rdy", 64'(1'b0), 64'(trn_tsrc_rdy));
    check_value("reset tsof", 64'(1'b0), 64'(trn_tsof));
    step_cycle();
    repeat (3) step_cycle();
    for (int v = 0; v < num_vectors; v++) begin
      send_packet(v);
    end
    $display("Checks: %0d, errors: %0d, cycles: %0d", check_count, error_count, cycle_count);
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+include
design/tx_pipeline_pkg.sv
design/tx_skid_buffer.sv
design/tx_link_ctrl.sv
design/tx_trn_format.sv
design/tx_pipeline_top.sv
test/tb_tx_pipeline.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f files.f --top-module tb_tx_pipeline \
		-Mdir obj_dir -o tb_tx_pipeline

run: compile
	./obj_dir/tb_tx_pipeline | tee sim.log
	grep -q "^Regression passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
